// File: rtl/memory_game_pkg.sv
package memory_game_pkg;

    ////////////////////
    // Card word
    ////////////////////

    // Colour is 4 bits each of red, green and blue with red at the top
    typedef struct packed {
        logic [11:0] color;
        logic        discovered;
        logic        active;
    } card_t;

    // Address 0 is the status word, 1 to 12 are the cards
    typedef logic [3:0] card_addr_t;

    // One of the eight fixed deal layouts
    typedef logic [2:0] layout_t;

    ////////////////////
    // Colours
    ////////////////////

    localparam logic [11:0] RED     = 12'hF00;
    localparam logic [11:0] GREEN   = 12'h0F0;
    localparam logic [11:0] BLUE    = 12'h00F;
    localparam logic [11:0] CYAN    = 12'h0FF;
    localparam logic [11:0] MAGENTA = 12'hF0F;
    localparam logic [11:0] YELLOW  = 12'hFF0;
    // White and black never appear on a dealt card
    localparam logic [11:0] WHITE   = 12'hFFF;
    localparam logic [11:0] BLACK   = 12'h000;

    ////////////////////
    // Board
    ////////////////////

    localparam int N_CARDS = 12;
    localparam int N_PAIRS = 6;

    // The status word keeps the pair count in its colour field
    localparam card_addr_t STATUS_ADDR = 4'd0;

endpackage

// File: rtl/card_port_if.sv
interface card_port_if
    import memory_game_pkg::*;
();

    // The one-cycle write strobe lands the word at the rising edge
    logic       wr_en;
    card_addr_t wr_addr;
    card_t      wr_data;

    // Read is combinational from rd_addr
    card_addr_t rd_addr;
    card_t      rd_data;

    modport master (
        output wr_en,
        output wr_addr,
        output wr_data,
        output rd_addr,
        input  rd_data
    );

    modport file (
        input  wr_en,
        input  wr_addr,
        input  wr_data,
        input  rd_addr,
        output rd_data
    );

endinterface

// File: rtl/card_deal.sv
module card_deal
    import memory_game_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        new_game,
    output logic        dealing,
    output logic        deal_done,
    output layout_t     layout,
    card_port_if.master port
);

    ////////////////////
    // Layout tables
    ////////////////////

    // Row is the layout index, column is the card position minus one
    localparam logic [11:0] LAYOUTS [8][12] = '{
        '{YELLOW, RED, BLUE, GREEN, CYAN, MAGENTA,
          CYAN, YELLOW, GREEN, MAGENTA, RED, BLUE},
        '{RED, GREEN, BLUE, CYAN, BLUE, RED,
          YELLOW, MAGENTA, CYAN, MAGENTA, YELLOW, GREEN},
        '{YELLOW, CYAN, GREEN, BLUE, YELLOW, BLUE,
          MAGENTA, MAGENTA, CYAN, RED, GREEN, RED},
        '{BLUE, MAGENTA, BLUE, GREEN, RED, CYAN,
          GREEN, CYAN, MAGENTA, RED, YELLOW, YELLOW},
        '{MAGENTA, CYAN, YELLOW, MAGENTA, GREEN, BLUE,
          GREEN, YELLOW, RED, CYAN, RED, BLUE},
        '{GREEN, CYAN, GREEN, MAGENTA, YELLOW, CYAN,
          RED, RED, BLUE, YELLOW, MAGENTA, BLUE},
        '{MAGENTA, GREEN, BLUE, BLUE, GREEN, RED,
          RED, YELLOW, CYAN, MAGENTA, CYAN, YELLOW},
        '{GREEN, RED, MAGENTA, YELLOW, RED, CYAN,
          YELLOW, GREEN, BLUE, MAGENTA, CYAN, BLUE}
    };

    layout_t     free_cnt;
    card_addr_t  addr;
    card_addr_t  card_idx;
    logic [11:0] table_color;

    ////////////////////
    // Sequencer
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            free_cnt  <= '0;
            layout    <= '0;
            dealing   <= 1'b0;
            deal_done <= 1'b0;
            addr      <= STATUS_ADDR;
        end else begin
            deal_done <= 1'b0;
            // The counter free-runs between deals so the layout depends on timing
            if (!dealing) begin
                free_cnt <= free_cnt + 3'd1;
            end
            if (!dealing && new_game) begin
                layout  <= free_cnt;
                dealing <= 1'b1;
                addr    <= STATUS_ADDR;
            end else if (dealing) begin
                if (addr == 4'(N_CARDS)) begin
                    dealing   <= 1'b0;
                    deal_done <= 1'b1;
                end else begin
                    addr <= addr + 4'd1;
                end
            end
        end
    end

    ////////////////////
    // Write side
    ////////////////////

    // Card at address n takes table column n-1
    assign card_idx = addr - 4'd1;

    always_comb begin
        if (addr != STATUS_ADDR && addr <= 4'(N_CARDS)) begin
            table_color = LAYOUTS[layout][card_idx];
        end else begin
            table_color = BLACK;
        end
    end

    assign port.wr_en   = dealing;
    assign port.wr_addr = addr;
    // The status word goes out as zero and every card starts active and covered
    assign port.wr_data = (addr == STATUS_ADDR) ? '0 :
                          card_t'{color: table_color, discovered: 1'b0, active: 1'b1};
    assign port.rd_addr = STATUS_ADDR;

    a_deal_addr_range : assert property (
        @(posedge clk) disable iff (rst)
        port.wr_en |-> port.wr_addr <= 4'(N_CARDS)
    ) else $error("dealer wrote outside the card file");

endmodule

// File: rtl/card_regfile.sv
module card_regfile
    import memory_game_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  card_addr_t disp_addr,
    output card_t      disp_data,
    card_port_if.file  deal_port,
    card_port_if.file  play_port
);

    // Word 0 is status, words 1 to 12 are cards
    card_t mem [0:N_CARDS];

    ////////////////////
    // Write
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i <= N_CARDS; i++) begin
                mem[i] <= '0;
            end
        end else if (deal_port.wr_en) begin
            // Dealer wins any conflict
            if (deal_port.wr_addr <= 4'(N_CARDS)) begin
                mem[deal_port.wr_addr] <= deal_port.wr_data;
            end
        end else if (play_port.wr_en) begin
            if (play_port.wr_addr <= 4'(N_CARDS)) begin
                mem[play_port.wr_addr] <= play_port.wr_data;
            end
        end
    end

    ////////////////////
    // Read
    ////////////////////

    // Addresses past the last card read as an empty word
    function automatic card_t read_word(input card_addr_t addr);
        card_t word;
        if (addr <= 4'(N_CARDS)) begin
            word = mem[addr];
        end else begin
            word = '0;
        end
        return word;
    endfunction

    assign deal_port.rd_data = read_word(deal_port.rd_addr);
    assign play_port.rd_data = read_word(play_port.rd_addr);
    assign disp_data         = read_word(disp_addr);

    // The judge keeps quiet while dealing, so the two ports never write together
    a_no_write_collision : assert property (
        @(posedge clk) disable iff (rst)
        !(deal_port.wr_en && play_port.wr_en)
    ) else $error("dealer and judge wrote in the same cycle");

endmodule

// File: rtl/pair_judge.sv
module pair_judge
    import memory_game_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        dealing,
    input  logic        pick,
    input  card_addr_t  pick_addr,
    output logic        busy,
    output logic        match,
    output logic        miss,
    output logic        game_won,
    card_port_if.master port
);

    typedef enum logic [2:0] {
        S_IDLE0,
        S_IDLE1,
        S_WR_SECOND,
        S_WR_FIRST,
        S_WR_STATUS
    } state_t;

    state_t      state;
    logic        idle;
    logic        pick_ok;
    logic [2:0]  pairs;
    logic [2:0]  pairs_inc;
    card_addr_t  held_addr;
    logic [11:0] held_color;
    card_addr_t  second_addr;
    logic [11:0] second_color;
    logic        is_match;

    ////////////////////
    // Pick check
    ////////////////////

    assign idle = (state == S_IDLE0) || (state == S_IDLE1);

    // Picks are looked up in the file while idle
    assign port.rd_addr = idle ? pick_addr : STATUS_ADDR;

    assign pick_ok = pick && idle && !dealing &&
                     (pick_addr != STATUS_ADDR) && (pick_addr <= 4'(N_CARDS)) &&
                     port.rd_data.active && !port.rd_data.discovered &&
                     !((state == S_IDLE1) && (pick_addr == held_addr));

    assign pairs_inc = pairs + 3'd1;

    ////////////////////
    // FSM
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE0;
            pairs <= '0;
            match <= 1'b0;
            miss  <= 1'b0;
        end else begin
            match <= 1'b0;
            miss  <= 1'b0;
            if (dealing) begin
                // A new deal drops any pair in progress
                state <= S_IDLE0;
                pairs <= '0;
            end else begin
                case (state)
                    S_IDLE0: if (pick_ok) state <= S_IDLE1;
                    S_IDLE1: if (pick_ok) state <= S_WR_SECOND;
                    S_WR_SECOND: state <= S_WR_FIRST;
                    S_WR_FIRST: begin
                        if (is_match) begin
                            state <= S_WR_STATUS;
                        end else begin
                            state <= S_IDLE0;
                            miss  <= 1'b1;
                        end
                    end
                    S_WR_STATUS: begin
                        pairs <= pairs_inc;
                        match <= 1'b1;
                        state <= S_IDLE0;
                    end
                    default: state <= S_IDLE0;
                endcase
            end
        end
    end

    // Held and second card details
    always_ff @(posedge clk) begin
        if (pick_ok && state == S_IDLE0) begin
            held_addr  <= pick_addr;
            held_color <= port.rd_data.color;
        end
        if (pick_ok && state == S_IDLE1) begin
            second_addr  <= pick_addr;
            second_color <= port.rd_data.color;
            is_match     <= (port.rd_data.color == held_color);
        end
    end

    ////////////////////
    // Writes
    ////////////////////

    always_comb begin
        port.wr_en   = 1'b0;
        port.wr_addr = STATUS_ADDR;
        port.wr_data = '0;
        case (state)
            S_IDLE0: begin
                // First card is uncovered right away
                port.wr_en   = pick_ok;
                port.wr_addr = pick_addr;
                port.wr_data = '{color: port.rd_data.color, discovered: 1'b1, active: 1'b1};
            end
            S_WR_SECOND: begin
                port.wr_en   = !dealing;
                port.wr_addr = second_addr;
                port.wr_data = '{color: second_color, discovered: is_match, active: !is_match};
            end
            S_WR_FIRST: begin
                port.wr_en   = !dealing;
                port.wr_addr = held_addr;
                port.wr_data = '{color: held_color, discovered: is_match, active: !is_match};
            end
            S_WR_STATUS: begin
                port.wr_en   = !dealing;
                port.wr_addr = STATUS_ADDR;
                port.wr_data = '{color: 12'(pairs_inc), discovered: 1'b0, active: 1'b0};
            end
            default: ;
        endcase
    end

    assign busy     = !idle;
    assign game_won = (pairs == 3'(N_PAIRS));

    a_match_miss_excl : assert property (
        @(posedge clk) disable iff (rst)
        !(match && miss)
    ) else $error("match and miss raised together");

endmodule

// File: rtl/memory_game_core.sv
module memory_game_core
    import memory_game_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        new_game,
    input  logic        pick,
    input  logic [3:0]  pick_addr,
    input  logic [3:0]  disp_addr,
    output logic [11:0] disp_color,
    output logic        disp_discovered,
    output logic        disp_active,
    output logic [2:0]  layout,
    output logic        dealing,
    output logic        deal_done,
    output logic        busy,
    output logic        match,
    output logic        miss,
    output logic        game_won
);

    card_t disp_data;

    card_port_if deal_port ();
    card_port_if play_port ();

    card_deal i_card_deal (
        .clk       (clk),
        .rst       (rst),
        .new_game  (new_game),
        .dealing   (dealing),
        .deal_done (deal_done),
        .layout    (layout),
        .port      (deal_port)
    );

    card_regfile i_card_regfile (
        .clk       (clk),
        .rst       (rst),
        .disp_addr (disp_addr),
        .disp_data (disp_data),
        .deal_port (deal_port),
        .play_port (play_port)
    );

    pair_judge i_pair_judge (
        .clk       (clk),
        .rst       (rst),
        .dealing   (dealing),
        .pick      (pick),
        .pick_addr (pick_addr),
        .busy      (busy),
        .match     (match),
        .miss      (miss),
        .game_won  (game_won),
        .port      (play_port)
    );

    // Display word split into plain outputs
    assign disp_color      = disp_data.color;
    assign disp_discovered = disp_data.discovered;
    assign disp_active     = disp_data.active;

endmodule

// File: testbench/tb_memory_game.sv
module tb_memory_game
    import memory_game_pkg::*;
();

    typedef enum logic [3:0] {
        T_RESET, T_NEW, T_READ, T_FIRST, T_SAME, T_MISS, T_MATCH, T_DEAD, T_CLEAR
    } op_t;

    // Addr is the card to pick, exp the pair count that a status read should show
    typedef struct packed {
        op_t        op;
        logic [3:0] addr;
        logic [3:0] exp;
    } step_t;

    ////////////////////
    // Stimulus table
    ////////////////////

    localparam int N_STEPS = 15;
    localparam step_t STEPS [N_STEPS] = '{
        '{T_RESET, 4'd0, 4'd0},
        '{T_NEW,   4'd0, 4'd0},
        '{T_FIRST, 4'd1, 4'd0},
        '{T_SAME,  4'd1, 4'd0},
        '{T_MISS,  4'd0, 4'd0},
        '{T_FIRST, 4'd2, 4'd0},
        '{T_MATCH, 4'd0, 4'd0},
        '{T_READ,  4'd0, 4'd1},
        '{T_DEAD,  4'd2, 4'd0},
        '{T_CLEAR, 4'd0, 4'd0},
        '{T_READ,  4'd0, 4'd6},
        '{T_NEW,   4'd0, 4'd0},
        '{T_FIRST, 4'd5, 4'd0},
        '{T_MATCH, 4'd0, 4'd0},
        '{T_READ,  4'd0, 4'd1}
    };

    // Colours of cards 1 to 12 in layout 0
    localparam logic [11:0] LAYOUT0 [12] = '{YELLOW, RED, BLUE, GREEN, CYAN, MAGENTA,
                                             CYAN, YELLOW, GREEN, MAGENTA, RED, BLUE};

    logic        clk = 1'b0;
    logic        rst, new_game, pick;
    logic [3:0]  pick_addr, disp_addr;
    logic [11:0] disp_color;
    logic [2:0]  layout;
    logic        disp_discovered, disp_active, dealing, deal_done;
    logic        busy, match, miss, game_won;

    // Expected board where word 0 mirrors the status word
    card_t  board [0:12] = '{default: '0};
    int     held, errors;
    integer seed = 8674;
    string  cur_test;

    memory_game_core i_memory_game_core (.*);

    always #5 clk = ~clk;

    ////////////////////
    // Checks
    ////////////////////

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s %s: expected %0h, actual %0h", cur_test, what, expected, actual);
            errors++;
        end
    endtask

    task automatic read_word(input int addr, output card_t word);
        @(posedge clk);
        disp_addr <= 4'(addr);
        @(negedge clk);
        word = {disp_color, disp_discovered, disp_active};
    endtask

    task automatic expect_word(input int addr);
        card_t word;
        read_word(addr, word);
        check($sformatf("word %0d", addr), 32'(board[addr]), 32'(word));
    endtask

    // Mode 0 wants a colour unlike the held card, 1 the same colour, 2 any colour
    function automatic int find_card(input int mode, input int skip);
        int found;
        found = 0;
        for (int i = N_CARDS; i >= 1; i--) begin
            if (board[i].active && !board[i].discovered && i != skip &&
                (mode == 2 || (board[i].color == board[held].color) == (mode == 1))) begin
                found = i;
            end
        end
        return found;
    endfunction

    ////////////////////
    // Player actions
    ////////////////////

    task automatic send_pick(input int addr);
        @(posedge clk);
        pick      <= 1'b1;
        pick_addr <= 4'(addr);
        @(posedge clk);
        pick <= 1'b0;
        @(negedge clk);
    endtask

    task automatic uncover_card(input int addr);
        send_pick(addr);
        check("busy after first pick", 0, 32'(busy));
        board[addr].discovered = 1'b1;
        held = addr;
        expect_word(addr);
    endtask

    // A dropped pick leaves busy low and the word as it was
    task automatic ignored_pick(input int addr);
        send_pick(addr);
        check("busy after dropped pick", 0, 32'(busy));
        expect_word(addr);
    endtask

    // The outcome comes from the expected board and a bystander pick lands while busy
    task automatic judge_pair(input int addr, input int bystander);
        logic same;
        int   n;
        same = (board[addr].color == board[held].color);
        n = 0;
        send_pick(addr);
        check("busy after second pick", 1, 32'(busy));
        if (bystander != 0) begin
            send_pick(bystander);
        end
        while (!match && !miss && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (!match && !miss) begin
            $display("Neither match nor miss came within 20 cycles in %s", cur_test);
            errors++;
        end
        check("match", 32'(same), 32'(match));
        check("miss", 32'(!same), 32'(miss));
        check("busy at outcome", 0, 32'(busy));
        board[addr] = '{color: board[addr].color, discovered: same, active: !same};
        board[held] = '{color: board[held].color, discovered: same, active: !same};
        if (same) begin
            board[0].color++;
        end
        check("game_won", 32'(board[0].color == 12'(N_PAIRS)), 32'(game_won));
        expect_word(held);
        expect_word(addr);
        expect_word(0);
        if (bystander != 0) begin
            expect_word(bystander);
        end
        held = 0;
    endtask

    task automatic clear_board();
        for (int a = 1; a <= N_CARDS; a++) begin
            if (board[a].active && !board[a].discovered) begin
                uncover_card(a);
                judge_pair(find_card(1, 0), 0);
            end
        end
    endtask

    // The idle gap moves the free layout counter before each deal
    task automatic start_deal();
        int n;
        int uses;
        n = 0;
        repeat (2 + (($random(seed) & 32'h7fff_ffff) % 9)) @(posedge clk);
        new_game <= 1'b1;
        @(posedge clk);
        new_game <= 1'b0;
        while (!deal_done && n < 40) begin
            @(negedge clk);
            n++;
        end
        if (!deal_done) begin
            $display("The deal did not finish within 40 cycles in %s", cur_test);
            errors++;
        end
        check("dealing at deal_done", 0, 32'(dealing));
        check("game_won after deal", 0, 32'(game_won));
        board[0] = '0;
        held = 0;
        expect_word(0);
        check("deal_done length", 0, 32'(deal_done));
        for (int i = 1; i <= N_CARDS; i++) begin
            read_word(i, board[i]);
            check($sformatf("flags of card %0d", i), 1,
                  32'({board[i].discovered, board[i].active}));
            check($sformatf("white or black card %0d", i), 0,
                  32'(board[i].color inside {WHITE, BLACK}));
            if (layout == 3'd0) begin
                check($sformatf("layout 0 card %0d", i), 32'(LAYOUT0[i - 1]),
                      32'(board[i].color));
            end
        end
        for (int i = 1; i <= N_CARDS; i++) begin
            uses = 0;
            for (int j = 1; j <= N_CARDS; j++) begin
                uses += int'(board[j].color == board[i].color);
            end
            check($sformatf("copies of colour on card %0d", i), 2, 32'(uses));
        end
    endtask

    initial begin
        step_t s;
        int    errors_before;
        int    tests_ok;
        rst       = 1'b1;
        new_game  = 1'b0;
        pick      = 1'b0;
        pick_addr = '0;
        disp_addr = '0;
        errors    = 0;
        held      = 0;
        tests_ok  = 0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < N_STEPS; i++) begin
            s = STEPS[i];
            cur_test = $sformatf("step %0d %s", i, s.op.name());
            errors_before = errors;
            case (s.op)
                T_RESET: begin
                    for (int a = 0; a <= N_CARDS; a++) begin
                        expect_word(a);
                    end
                    check("control outputs", 0,
                          32'({layout, dealing, deal_done, busy, match, miss, game_won}));
                end
                T_NEW:   start_deal();
                T_READ: begin
                    check("pair count", 32'(s.exp), 32'(board[0].color));
                    expect_word(0);
                end
                T_FIRST: uncover_card(int'(s.addr));
                T_SAME:  ignored_pick(held);
                T_MISS:  judge_pair(find_card(0, 0), find_card(2, find_card(0, 0)));
                T_MATCH: judge_pair(find_card(1, 0), 0);
                T_DEAD:  ignored_pick(int'(s.addr));
                T_CLEAR: clear_board();
                default: ;
            endcase
            if (errors == errors_before) begin
                tests_ok++;
                $display("%s: ok", cur_test);
            end else begin
                $display("%s: wrong", cur_test);
            end
        end
        $display("%0d of %0d tests ok, %0d errors", tests_ok, N_STEPS, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Allows 200 cycles for each table row
    initial begin
        repeat (200 * N_STEPS) @(posedge clk);
        $display("Watchdog: the run timed out after %0d cycles", 200 * N_STEPS);
        $display("** FAIL **");
        $finish;
    end

endmodule

// File: src.f
rtl/memory_game_pkg.sv
rtl/card_port_if.sv
rtl/card_deal.sv
rtl/card_regfile.sv
rtl/pair_judge.sv
rtl/memory_game_core.sv
testbench/tb_memory_game.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_memory_game -o tb_memory_game
./obj_dir/tb_memory_game | tee sim.log

if grep -qF "** PASS **" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
